//--- fma_cases.txt
# op high a b c expected_data expected_ovf, op and high and ovf in decimal, the rest in hex
# op codes: 0 madd, 1 msub, 2 nmsub, 3 nmadd, 4 add, 5 sub, 6 mul, 7 imul
0 0 00000003 00000004 00000005 00000011 0
1 0 00000007 00000006 00000002 00000028 0
2 0 00000005 00000005 00000064 0000004b 0
3 0 00000002 00000003 00000004 fffffff6 0
4 0 7fffffff 00000001 00000000 80000000 1
7 0 00010000 00010000 00000000 00000000 0
7 1 00010000 00010000 00000000 00000001 0
5 0 80000000 00000001 00000000 7fffffff 1
6 0 00010000 00008000 00000000 80000000 1
6 0 fffffffd 00000007 00000000 ffffffeb 0
7 1 fffffffd 00000007 00000000 ffffffff 0
7 0 12345678 00000010 00000000 23456780 0
0 0 40000000 00000002 ffffffff 7fffffff 0
3 0 80000000 00000001 00000000 80000000 1
2 0 ffffffff 80000000 80000000 00000000 1
1 0 00000000 00000005 80000000 80000000 1
5 0 00000005 fffffffb 00000000 0000000a 0
4 0 fffffff0 00000010 00000000 00000000 0
7 1 80000000 80000000 00000000 40000000 0
7 0 ffffffff ffffffff 00000000 00000001 0
0 0 7fffffff 7fffffff 00000000 00000001 1
6 0 00001000 00001000 00000000 01000000 0

//--- fma_pipe.f
fma_pkg.sv
fma_dispatch.sv
fma_muladd_core.sv
fma_result_queue.sv
fma_pipe.sv
tb_fma_pipe.sv

//--- run_sim.sh
#!/bin/sh
# compile the multiply-add pipe testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fma_pipe -f fma_pipe.f -o sim_fma_pipe

./obj_dir/sim_fma_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb_fma_pipe.sv
// self-checking testbench that drives the multiply-add pipe from a case file
`default_nettype none

module tb_fma_pipe;

  import fma_pkg::*;

  typedef struct packed {
    fma_op_e                  op;
    logic                     high;
    logic [data_width_lp-1:0] a;
    logic [data_width_lp-1:0] b;
    logic [data_width_lp-1:0] c;
    logic [data_width_lp-1:0] exp_data;
    logic                     exp_ovf;
  } case_t;

  logic                     clk;
  logic                     arst_n;
  logic                     in_valid;
  logic                     in_ready;
  fma_op_e                  op;
  logic                     imul_high;
  logic [data_width_lp-1:0] a;
  logic [data_width_lp-1:0] b;
  logic [data_width_lp-1:0] c;
  logic                     fma_valid;
  logic                     fma_ready;
  logic [data_width_lp-1:0] fma_data;
  logic                     fma_ovf;
  logic                     imul_valid;
  logic                     imul_ready;
  logic [data_width_lp-1:0] imul_data;

  case_t        case_q[$];
  fma_result_t  fma_exp_q[$];
  imul_result_t imul_exp_q[$];
  logic         cases_loaded = 1'b0;
  logic [15:0]  lfsr_state;
  int           fma_errors = 0;
  int           imul_errors = 0;
  int           other_errors = 0;
  int           fma_accepted = 0;
  int           imul_accepted = 0;
  int           fma_popped = 0;
  int           imul_popped = 0;

  fma_pipe dut
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.in_valid_i(in_valid)
     ,.in_ready_o(in_ready)
     ,.op_i(op)
     ,.imul_high_i(imul_high)
     ,.a_i(a)
     ,.b_i(b)
     ,.c_i(c)
     ,.fma_valid_o(fma_valid)
     ,.fma_ready_i(fma_ready)
     ,.fma_data_o(fma_data)
     ,.fma_ovf_o(fma_ovf)
     ,.imul_valid_o(imul_valid)
     ,.imul_ready_i(imul_ready)
     ,.imul_data_o(imul_data)
     );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // galois step with the taps of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0])
      return (state >> 1) ^ 16'hB400;
    return state >> 1;
  endfunction

  task automatic load_cases();
    int                       fd;
    int                       n;
    string                    line;
    logic [2:0]               op_bits;
    logic                     high_bit;
    logic [data_width_lp-1:0] a_v;
    logic [data_width_lp-1:0] b_v;
    logic [data_width_lp-1:0] c_v;
    logic [data_width_lp-1:0] d_v;
    logic                     ovf_v;
    case_t                    entry;
    fd = $fopen("fma_cases.txt", "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("could not open the case file fma_cases.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      if ($fgets(line, fd) != 0)
      begin
        // header lines start with a hash and match none of the fields
        n = $sscanf(line, "%d %d %h %h %h %h %d",
                    op_bits, high_bit, a_v, b_v, c_v, d_v, ovf_v);
        if (n == 7)
        begin
          entry.op       = fma_op_e'(op_bits);
          entry.high     = high_bit;
          entry.a        = a_v;
          entry.b        = b_v;
          entry.c        = c_v;
          entry.exp_data = d_v;
          entry.exp_ovf  = ovf_v;
          case_q.push_back(entry);
        end
      end
    end
    $fclose(fd);
    if (case_q.size() == 0)
    begin
      other_errors++;
      $display("the case file held no usable cases");
    end
  endtask

  task automatic record_accept(input case_t cur);
    fma_result_t  exp_fma;
    imul_result_t exp_imul;
    if (cur.op == e_op_imul)
    begin
      exp_imul.data = cur.exp_data;
      imul_exp_q.push_back(exp_imul);
      imul_accepted++;
    end
    else
    begin
      exp_fma.data = cur.exp_data;
      exp_fma.ovf  = cur.exp_ovf;
      fma_exp_q.push_back(exp_fma);
      fma_accepted++;
    end
  endtask

  task automatic compare_fma(input fma_result_t got, input fma_result_t exp, input int idx);
    if (got !== exp)
    begin
      fma_errors++;
      $display("[ERROR] %0t fma result %0d: got %h ovf %b, expected %h ovf %b",
               $time, idx, got.data, got.ovf, exp.data, exp.ovf);
    end
  endtask

  task automatic compare_imul(input imul_result_t got, input imul_result_t exp, input int idx);
    if (got !== exp)
    begin
      imul_errors++;
      $display("[ERROR] %0t imul result %0d: got %h, expected %h",
               $time, idx, got.data, exp.data);
    end
  endtask

  // both readies start low so that the fma credits run out first
  initial
  begin : ready_driver
    fma_ready  = 1'b0;
    imul_ready = 1'b0;
    lfsr_state = 16'd51298;
    @(posedge arst_n);
    repeat (20) @(negedge clk);
    if (fma_accepted > queue_depth_lp)
    begin
      other_errors++;
      $display("with fma ready held low the pipe took %0d fma operations", fma_accepted);
    end
    // fma results drain at random while imul ready stays low until an imul stalls
    do
    begin
      @(posedge clk);
      fma_ready <= lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      @(negedge clk);
    end
    while (in_valid && imul_accepted <= queue_depth_lp
           && !(op == e_op_imul && !in_ready));
    if (imul_accepted > queue_depth_lp)
    begin
      other_errors++;
      $display("with imul ready held low the pipe took %0d imul operations", imul_accepted);
    end
    forever
    begin
      @(posedge clk);
      fma_ready  <= lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      imul_ready <= lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  end

  // a transfer is taken at the next rising edge when valid and ready are high here
  always @(negedge clk)
  begin : result_monitor
    fma_result_t  got_fma;
    imul_result_t got_imul;
    if (arst_n && fma_valid && fma_ready)
    begin
      got_fma.data = fma_data;
      got_fma.ovf  = fma_ovf;
      if (fma_exp_q.size() == 0)
      begin
        other_errors++;
        $display("the fma port returned a result with nothing outstanding at %0t", $time);
      end
      else
        compare_fma(got_fma, fma_exp_q.pop_front(), fma_popped);
      fma_popped++;
    end
    if (arst_n && imul_valid && imul_ready)
    begin
      got_imul.data = imul_data;
      if (imul_exp_q.size() == 0)
      begin
        other_errors++;
        $display("the imul port returned a result with nothing outstanding at %0t", $time);
      end
      else
        compare_imul(got_imul, imul_exp_q.pop_front(), imul_popped);
      imul_popped++;
    end
  end

  initial
  begin : watchdog
    int limit_cycles;
    wait (cases_loaded);
    limit_cycles = case_q.size() * 40 + 200;
    #(limit_cycles * 20);
    $display("timeout: results still missing after %0d cycles", limit_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin : stimulus
    case_t cur;
    logic  took;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    op        = e_op_madd;
    imul_high = 1'b0;
    a         = '0;
    b         = '0;
    c         = '0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (fma_valid !== 1'b0 || imul_valid !== 1'b0 || in_ready !== 1'b1)
    begin
      other_errors++;
      $display("[ERROR] %0t after reset: fma_valid %b imul_valid %b in_ready %b",
               $time, fma_valid, imul_valid, in_ready);
    end
    foreach (case_q[i])
    begin
      cur = case_q[i];
      @(posedge clk);
      in_valid  <= 1'b1;
      op        <= cur.op;
      imul_high <= cur.high;
      a         <= cur.a;
      b         <= cur.b;
      c         <= cur.c;
      took = 1'b0;
      while (!took)
      begin
        @(negedge clk);
        took = in_ready;
        if (!took)
          @(posedge clk);
      end
      record_accept(cur);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    while (fma_exp_q.size() != 0 || imul_exp_q.size() != 0)
      @(negedge clk);
    // any duplicate that turns up now is caught by the monitor
    repeat (20) @(negedge clk);
    $display("errors: fma %0d, imul %0d, other %0d", fma_errors, imul_errors, other_errors);
    if (fma_errors + imul_errors + other_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- fma_pipe.sv
// multiply-add execution pipe top with dispatch, shared core and two result queues
`default_nettype none

module fma_pipe
  (input wire                                clk_i
   , input wire                              arst_n_i

   , input wire                              in_valid_i
   , output logic                            in_ready_o
   , input wire fma_pkg::fma_op_e            op_i
   , input wire                              imul_high_i
   , input wire [fma_pkg::data_width_lp-1:0] a_i
   , input wire [fma_pkg::data_width_lp-1:0] b_i
   , input wire [fma_pkg::data_width_lp-1:0] c_i

   , output logic                            fma_valid_o
   , input wire                              fma_ready_i
   , output logic [fma_pkg::data_width_lp-1:0] fma_data_o
   , output logic                            fma_ovf_o

   , output logic                            imul_valid_o
   , input wire                              imul_ready_i
   , output logic [fma_pkg::data_width_lp-1:0] imul_data_o
   );

  import fma_pkg::*;

  logic                     issue_fma;
  logic                     issue_imul;
  muladd_ctl_e              ctl;
  logic                     imul_high;
  logic [data_width_lp-1:0] mul_a;
  logic [data_width_lp-1:0] mul_b;
  logic [data_width_lp-1:0] add_c;
  logic                     fma_v;
  fma_result_t              fma_res;
  logic                     imul_v;
  imul_result_t             imul_res;
  logic                     fma_pop;
  logic                     imul_pop;
  fma_result_t              fma_head;
  imul_result_t             imul_head;

  fma_dispatch dispatch
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.in_valid_i(in_valid_i)
     ,.op_i(op_i)
     ,.imul_high_i(imul_high_i)
     ,.a_i(a_i)
     ,.b_i(b_i)
     ,.c_i(c_i)
     ,.in_ready_o(in_ready_o)
     ,.fma_pop_i(fma_pop)
     ,.imul_pop_i(imul_pop)
     ,.issue_fma_o(issue_fma)
     ,.issue_imul_o(issue_imul)
     ,.ctl_o(ctl)
     ,.imul_high_o(imul_high)
     ,.mul_a_o(mul_a)
     ,.mul_b_o(mul_b)
     ,.add_c_o(add_c)
     );

  fma_muladd_core core
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.issue_fma_i(issue_fma)
     ,.issue_imul_i(issue_imul)
     ,.ctl_i(ctl)
     ,.imul_high_i(imul_high)
     ,.mul_a_i(mul_a)
     ,.mul_b_i(mul_b)
     ,.add_c_i(add_c)
     ,.fma_v_o(fma_v)
     ,.fma_res_o(fma_res)
     ,.imul_v_o(imul_v)
     ,.imul_res_o(imul_res)
     );

  fma_result_queue #(.payload_t(fma_result_t)) fma_queue
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.push_i(fma_v)
     ,.push_data_i(fma_res)
     ,.valid_o(fma_valid_o)
     ,.ready_i(fma_ready_i)
     ,.data_o(fma_head)
     ,.pop_o(fma_pop)
     );

  fma_result_queue #(.payload_t(imul_result_t)) imul_queue
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.push_i(imul_v)
     ,.push_data_i(imul_res)
     ,.valid_o(imul_valid_o)
     ,.ready_i(imul_ready_i)
     ,.data_o(imul_head)
     ,.pop_o(imul_pop)
     );

  assign fma_data_o  = fma_head.data;
  assign fma_ovf_o   = fma_head.ovf;
  assign imul_data_o = imul_head.data;

endmodule

`default_nettype wire

//--- fma_result_queue.sv
// result FIFO with a typed payload, valid/ready output and a pop pulse back to dispatch
`default_nettype none

module fma_result_queue
  #(parameter type payload_t = logic [fma_pkg::data_width_lp-1:0])
  (input wire           clk_i
   , input wire         arst_n_i

   , input wire         push_i
   , input wire payload_t push_data_i

   , output logic       valid_o
   , input wire         ready_i
   , output payload_t   data_o

   , output logic       pop_o
   );

  import fma_pkg::*;

  payload_t                   mem_r [queue_depth_lp];
  logic [ptr_width_lp-1:0]    rd_ptr_r;
  logic [ptr_width_lp-1:0]    wr_ptr_r;
  logic [credit_width_lp-1:0] count_r;
  logic                       full;
  logic                       pop;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(queue_depth_lp - 1))
      return '0;
    return ptr + ptr_width_lp'(1);
  endfunction

  assign valid_o = (count_r != '0);
  assign full    = (count_r == credit_width_lp'(queue_depth_lp));
  assign pop     = valid_o && ready_i;
  assign pop_o   = pop;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wr_ptr_r] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (pop)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      case ({push_i, pop})
        2'b10:   count_r <= count_r + credit_width_lp'(1);
        2'b01:   count_r <= count_r - credit_width_lp'(1);
        default: count_r <= count_r;
      endcase
    end
  end

  // dispatch holds a credit for every entry, so the core can never overfill us
  no_overflow_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full);

endmodule

`default_nettype wire

//--- fma_muladd_core.sv
// pipelined signed multiply-add core with an early integer product tap
`default_nettype none

module fma_muladd_core
  (input wire                                clk_i
   , input wire                              arst_n_i

   , input wire                              issue_fma_i
   , input wire                              issue_imul_i
   , input wire fma_pkg::muladd_ctl_e        ctl_i
   , input wire                              imul_high_i
   , input wire [fma_pkg::data_width_lp-1:0] mul_a_i
   , input wire [fma_pkg::data_width_lp-1:0] mul_b_i
   , input wire [fma_pkg::data_width_lp-1:0] add_c_i

   , output logic                            fma_v_o
   , output fma_pkg::fma_result_t            fma_res_o
   , output logic                            imul_v_o
   , output fma_pkg::imul_result_t           imul_res_o
   );

  import fma_pkg::*;

  logic [fma_latency_lp-1:0]  fma_v_r;
  logic [imul_latency_lp-1:0] imul_v_r;

  // stage one holds the raw product and the controls
  logic signed [prod_width_lp-1:0] prod_s1_r;
  logic signed [data_width_lp-1:0] addend_s1_r;
  muladd_ctl_e                     ctl_s1_r;
  logic                            imul_high_s1_r;

  // stage two holds the signed terms and the integer result
  logic                            neg_prod_s1;
  logic                            neg_addend_s1;
  logic signed [data_width_lp:0]   addend_ext_s1;
  logic signed [prod_width_lp-1:0] prod_term_s2_r;
  logic signed [data_width_lp:0]   addend_term_s2_r;
  imul_result_t                    imul_res_r;

  // stage three holds the wrapped sum and its overflow
  logic signed [prod_width_lp-1:0]         sum_s2;
  logic [prod_width_lp-data_width_lp:0]    sum_upper_s2;
  logic                                    ovf_s2;
  fma_result_t                             fma_res_r;

  // the data stages never stall, so the valid bits just shift along
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      fma_v_r  <= '0;
      imul_v_r <= '0;
    end
    else
    begin
      fma_v_r  <= {fma_v_r[fma_latency_lp-2:0], issue_fma_i};
      imul_v_r <= {imul_v_r[imul_latency_lp-2:0], issue_imul_i};
    end
  end

  assign fma_v_o  = fma_v_r[fma_latency_lp-1];
  assign imul_v_o = imul_v_r[imul_latency_lp-1];

  always_ff @(posedge clk_i)
  begin
    prod_s1_r      <= $signed(mul_a_i) * $signed(mul_b_i);
    addend_s1_r    <= $signed(add_c_i);
    ctl_s1_r       <= ctl_i;
    imul_high_s1_r <= imul_high_i;
  end

  assign neg_prod_s1   = (ctl_s1_r == e_ctl_mp) || (ctl_s1_r == e_ctl_mm);
  assign neg_addend_s1 = (ctl_s1_r == e_ctl_pm) || (ctl_s1_r == e_ctl_mm);

  // one extra bit so that negating the most negative addend stays exact
  assign addend_ext_s1 = addend_s1_r;

  always_ff @(posedge clk_i)
  begin
    prod_term_s2_r   <= neg_prod_s1 ? -prod_s1_r : prod_s1_r;
    addend_term_s2_r <= neg_addend_s1 ? -addend_ext_s1 : addend_ext_s1;
    imul_res_r.data  <= imul_high_s1_r ? prod_s1_r[prod_width_lp-1:data_width_lp]
                                       : prod_s1_r[data_width_lp-1:0];
  end

  assign sum_s2 = prod_term_s2_r + addend_term_s2_r;

  // the sum fits in 32 bits only if every bit above bit 30 matches the sign
  assign sum_upper_s2 = sum_s2[prod_width_lp-1:data_width_lp-1];
  assign ovf_s2 = !((&sum_upper_s2) || (~|sum_upper_s2));

  always_ff @(posedge clk_i)
  begin
    fma_res_r.data <= sum_s2[data_width_lp-1:0];
    fma_res_r.ovf  <= ovf_s2;
  end

  assign fma_res_o  = fma_res_r;
  assign imul_res_o = imul_res_r;

  // dispatch sends at most one operation per cycle
  single_issue_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(issue_fma_i && issue_imul_i));

endmodule

`default_nettype wire

//--- fma_dispatch.sv
// dispatch stage that maps operations onto the shared core and tracks queue credits
`default_nettype none

module fma_dispatch
  (input wire                                clk_i
   , input wire                              arst_n_i

   , input wire                              in_valid_i
   , input wire fma_pkg::fma_op_e            op_i
   , input wire                              imul_high_i
   , input wire [fma_pkg::data_width_lp-1:0] a_i
   , input wire [fma_pkg::data_width_lp-1:0] b_i
   , input wire [fma_pkg::data_width_lp-1:0] c_i
   , output logic                            in_ready_o

   , input wire                              fma_pop_i
   , input wire                              imul_pop_i

   , output logic                            issue_fma_o
   , output logic                            issue_imul_o
   , output fma_pkg::muladd_ctl_e            ctl_o
   , output logic                            imul_high_o
   , output logic [fma_pkg::data_width_lp-1:0] mul_a_o
   , output logic [fma_pkg::data_width_lp-1:0] mul_b_o
   , output logic [fma_pkg::data_width_lp-1:0] add_c_o
   );

  import fma_pkg::*;

  logic                       is_imul;
  logic                       accept;
  logic [credit_width_lp-1:0] fma_credit_r;
  logic [credit_width_lp-1:0] fma_credit_n;
  logic [credit_width_lp-1:0] imul_credit_r;
  logic [credit_width_lp-1:0] imul_credit_n;

  assign is_imul = (op_i == e_op_imul);

  // an operation may only go when its own result queue has room reserved
  assign in_ready_o = is_imul ? (imul_credit_r != '0) : (fma_credit_r != '0);
  assign accept = in_valid_i && in_ready_o;

  assign issue_fma_o  = accept && !is_imul;
  assign issue_imul_o = accept && is_imul;
  assign imul_high_o  = imul_high_i;

  // add and sub multiply by one with b as the addend, mul adds zero
  always_comb
  begin
    ctl_o   = e_ctl_pp;
    mul_a_o = a_i;
    mul_b_o = b_i;
    add_c_o = c_i;
    case (op_i)
      e_op_msub:  ctl_o = e_ctl_pm;
      e_op_nmsub: ctl_o = e_ctl_mp;
      e_op_nmadd: ctl_o = e_ctl_mm;
      e_op_add:
      begin
        mul_b_o = data_width_lp'(1);
        add_c_o = b_i;
      end
      e_op_sub:
      begin
        ctl_o   = e_ctl_pm;
        mul_b_o = data_width_lp'(1);
        add_c_o = b_i;
      end
      e_op_mul, e_op_imul: add_c_o = '0;
      default: ctl_o = e_ctl_pp;
    endcase
  end

  // a credit leaves on issue and comes back when the queue pops
  always_comb
  begin
    fma_credit_n = fma_credit_r;
    if (issue_fma_o && !fma_pop_i)
      fma_credit_n = fma_credit_r - credit_width_lp'(1);
    else if (!issue_fma_o && fma_pop_i)
      fma_credit_n = fma_credit_r + credit_width_lp'(1);

    imul_credit_n = imul_credit_r;
    if (issue_imul_o && !imul_pop_i)
      imul_credit_n = imul_credit_r - credit_width_lp'(1);
    else if (!issue_imul_o && imul_pop_i)
      imul_credit_n = imul_credit_r + credit_width_lp'(1);
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      fma_credit_r  <= credit_width_lp'(queue_depth_lp);
      imul_credit_r <= credit_width_lp'(queue_depth_lp);
    end
    else
    begin
      fma_credit_r  <= fma_credit_n;
      imul_credit_r <= imul_credit_n;
    end
  end

  // pops must never outnumber issues on either queue
  credit_bound_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (fma_credit_r <= credit_width_lp'(queue_depth_lp))
    && (imul_credit_r <= credit_width_lp'(queue_depth_lp)));

endmodule

`default_nettype wire

//--- fma_pkg.sv
// multiply-add pipe shared widths, latencies, operation codes and result payloads
`default_nettype none

package fma_pkg;

  // operand and result width
  localparam int data_width_lp = 32;

  // full signed product of two operands
  localparam int prod_width_lp = 64;

  // cycles from acceptance to the core's multiply-add result
  localparam int fma_latency_lp = 3;

  // cycles from acceptance to the core's integer product
  localparam int imul_latency_lp = 2;

  // entries per result queue, which is also the starting credit count
  localparam int queue_depth_lp = 4;

  localparam int ptr_width_lp = $clog2(queue_depth_lp);

  // wide enough to hold every count from zero to a full queue
  localparam int credit_width_lp = $clog2(queue_depth_lp + 1);

  typedef enum logic [2:0] {
    e_op_madd  = 3'd0,
    e_op_msub  = 3'd1,
    e_op_nmsub = 3'd2,
    e_op_nmadd = 3'd3,
    e_op_add   = 3'd4,
    e_op_sub   = 3'd5,
    e_op_mul   = 3'd6,
    e_op_imul  = 3'd7
  } fma_op_e;

  // sign controls of the core
  //   pp :   (a x b) + c
  //   pm :   (a x b) - c
  //   mp : - (a x b) + c
  //   mm : - (a x b) - c
  typedef enum logic [1:0] {
    e_ctl_pp = 2'b00,
    e_ctl_pm = 2'b01,
    e_ctl_mp = 2'b10,
    e_ctl_mm = 2'b11
  } muladd_ctl_e;

  // the overflow bit stands in for the exception flags
  typedef struct packed {
    logic [data_width_lp-1:0] data;
    logic                     ovf;
  } fma_result_t;

  typedef struct packed {
    logic [data_width_lp-1:0] data;
  } imul_result_t;

endpackage

`default_nettype wire
